//--- Bender.yml
package:
  name: ifu

sources:
  - files:
      - common/ifu_cfg_pkg.sv
      - common/ifu_inst_pkg.sv
      - hw/fetch/ifu_fetch_ctl.sv
      - hw/bpred/ifu_bp_ctl.sv
      - hw/aligner/ifu_aln_ctl.sv
      - hw/ifu_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/ifu_sva.sv
      - testbench/tb_ifu.sv

//--- common/ifu_cfg_pkg.sv
//****************************************
// ifu configuration package
// sizes, reset vector and btb geometry
//****************************************
`default_nettype none

package ifu_cfg_pkg;

   //****************************************
   // fetch address
   //****************************************
   localparam int PC_W = 31;                              // halfword pc, bits 31:1
   localparam logic [31:0] RESET_VECTOR = 32'h0000_0200;  // first fetch address

   //****************************************
   // branch target buffer
   //****************************************
   localparam int BTB_DEPTH   = 16;                       // direct mapped entries
   localparam int BTB_INDEX_W = $clog2(BTB_DEPTH);        // index width
   localparam int BTB_INDEX_LO = 2;                       // index starts at word address
   localparam int BTB_TAG_W   = 8;                        // tag bits above the index
   localparam int BTB_TAG_LO  = BTB_INDEX_LO + BTB_INDEX_W;

   // 2-bit saturating counter, msb set means taken
   localparam int CNT_W = 2;
   localparam logic [CNT_W-1:0] CNT_WEAK_TAKEN = 2'b10;   // value on allocation

endpackage : ifu_cfg_pkg

`default_nettype wire

//--- common/ifu_inst_pkg.sv
//****************************************
// ifu instruction package
// word type seen as one 32-bit instr or as two parcels
//****************************************
`default_nettype none

package ifu_inst_pkg;

   localparam int PARCEL_W = 16;                  // compressed parcel width
   localparam logic [1:0] OPC_FULL = 2'b11;       // low bits of a 32-bit instr

   //****************************************
   // instruction word, two views
   //****************************************
   typedef union packed {
      logic [2*PARCEL_W-1:0]            full;     // whole word as one instruction
      logic [1:0][PARCEL_W-1:0]         parcel;   // parcel[0] is the low halfword
   } inst_word_u;

endpackage : ifu_inst_pkg

`default_nettype wire

//--- flist.f
common/ifu_cfg_pkg.sv
common/ifu_inst_pkg.sv
hw/fetch/ifu_fetch_ctl.sv
hw/bpred/ifu_bp_ctl.sv
hw/aligner/ifu_aln_ctl.sv
hw/ifu_top.sv
testbench/tb_clk_gen.sv
testbench/ifu_sva.sv
testbench/tb_ifu.sv

//--- hw/aligner/ifu_aln_ctl.sv
//****************************************
// ifu aligner
// parcels of f2 words to up to two instructions
//****************************************
`timescale 1ns/1ps
`default_nettype none

module ifu_aln_ctl
   import ifu_cfg_pkg::*;
   import ifu_inst_pkg::*;
(
   input  logic                          clk,
   input  logic                          arst_n,
   input  logic                          fetch_val_f2,
   input  logic [PC_W:1]                 fetch_pc_f2,
   input  logic                          fetch_restart_f2,
   input  logic [2*PARCEL_W-1:0]         ic_rd_data,
   input  logic                          bp_taken_f2,
   input  logic                          bp_boffset_f2,
   input  logic [PC_W:1]                 bp_target_f2,
   output logic                          ifu_i0_valid,
   output logic [$bits(inst_word_u)-1:0] ifu_i0_instr,
   output logic [PC_W:1]                 ifu_i0_pc,
   output logic                          ifu_i0_pc4,
   output logic                          ifu_i0_br_taken,
   output logic [PC_W:1]                 ifu_i0_br_target,
   output logic                          ifu_i1_valid,
   output logic [$bits(inst_word_u)-1:0] ifu_i1_instr,
   output logic [PC_W:1]                 ifu_i1_pc,
   output logic                          ifu_i1_pc4,
   output logic                          ifu_i1_br_taken,
   output logic [PC_W:1]                 ifu_i1_br_target
);

   inst_word_u                   word_f2;     // fetched word
   inst_word_u                   pair;        // candidate instruction
   logic [2:0]                   cand_val;    // leftover, low parcel, high parcel
   logic [2:0]                   cand_br;
   logic [2:0][PARCEL_W-1:0]     cand_par;
   logic [2:0][PC_W:1]           cand_pc;
   logic [3:0][PARCEL_W-1:0]     seq_par;     // packed parcel stream, oldest first
   logic [3:0][PC_W:1]           seq_pc;
   logic [3:0]                   seq_br;
   logic [2:0]                   seq_n;
   logic [2:0]                   pos;         // next unused parcel
   logic                         is_full;
   logic                         keep_lo;
   logic [1:0]                   slot_val;
   logic [1:0]                   slot_pc4;
   logic [1:0]                   slot_br;
   logic [1:0][31:0]             slot_instr;
   logic [1:0][PC_W:1]           slot_pc;
   logic                         lo_val;      // leftover parcel held
   logic [PARCEL_W-1:0]          lo_par;
   logic [PC_W:1]                lo_pc;

   assign word_f2 = ic_rd_data;

   //****************************************
   // live parcels of the f2 word
   //****************************************
   assign cand_val[0] = lo_val & ~(fetch_val_f2 & fetch_restart_f2);  // restart empties it
   assign cand_val[1] = fetch_val_f2 & ~fetch_pc_f2[1];               // odd start drops low
   assign cand_val[2] = fetch_val_f2 & ~(bp_taken_f2 & ~bp_boffset_f2);  // after branch end
   assign cand_par    = {word_f2.parcel[1], word_f2.parcel[0], lo_par};
   assign cand_pc     = {{fetch_pc_f2[PC_W:2], 1'b1}, {fetch_pc_f2[PC_W:2], 1'b0}, lo_pc};
   assign cand_br     = {bp_taken_f2 & bp_boffset_f2, bp_taken_f2 & ~bp_boffset_f2, 1'b0};

   // squeeze out dropped parcels
   always_comb begin
      seq_par = '0;
      seq_pc  = '0;
      seq_br  = '0;
      seq_n   = '0;
      for (int c = 0; c < 3; c++) begin
         if (cand_val[c]) begin
            seq_par[seq_n[1:0]] = cand_par[c];
            seq_pc[seq_n[1:0]]  = cand_pc[c];
            seq_br[seq_n[1:0]]  = cand_br[c];
            seq_n               = seq_n + 3'd1;
         end
      end
   end

   //****************************************
   // extraction, two slots in order
   //****************************************
   always_comb begin
      pos  = '0;
      pair = '0;
      is_full = 1'b0;
      for (int s = 0; s < 2; s++) begin
         is_full        = (seq_par[pos[1:0]][1:0] == OPC_FULL);  // low bits pick length
         pair.parcel[0] = seq_par[pos[1:0]];
         pair.parcel[1] = seq_par[pos[1:0] + 2'd1];
         slot_val[s]    = (pos < seq_n) && (!is_full || (pos + 3'd1 < seq_n));
         slot_pc4[s]    = is_full;
         slot_instr[s]  = is_full ? pair.full : {{PARCEL_W{1'b0}}, pair.parcel[0]};
         slot_pc[s]     = seq_pc[pos[1:0]];
         slot_br[s]     = is_full ? seq_br[pos[1:0] + 2'd1] : seq_br[pos[1:0]];  // end parcel
         if (slot_val[s]) begin
            pos = pos + (is_full ? 3'd2 : 3'd1);
         end
      end
      keep_lo = (pos < seq_n);   // lone first half of a 32-bit instr
   end

   //****************************************
   // output and leftover registers
   //****************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ifu_i0_valid <= 1'b0;
         ifu_i1_valid <= 1'b0;
         lo_val       <= 1'b0;
      end else begin
         ifu_i0_valid <= slot_val[0];
         ifu_i1_valid <= slot_val[1];   // never without slot 0
         lo_val       <= keep_lo;
      end
   end

   always_ff @(posedge clk) begin
      ifu_i0_instr     <= slot_instr[0];
      ifu_i0_pc        <= slot_pc[0];
      ifu_i0_pc4       <= slot_pc4[0];
      ifu_i0_br_taken  <= slot_br[0];
      ifu_i0_br_target <= slot_br[0] ? bp_target_f2 : '0;
      ifu_i1_instr     <= slot_instr[1];
      ifu_i1_pc        <= slot_pc[1];
      ifu_i1_pc4       <= slot_pc4[1];
      ifu_i1_br_taken  <= slot_br[1];
      ifu_i1_br_target <= slot_br[1] ? bp_target_f2 : '0;
      if (keep_lo) begin
         lo_par <= seq_par[pos[1:0]];
         lo_pc  <= seq_pc[pos[1:0]];
      end
   end

endmodule : ifu_aln_ctl

`default_nettype wire

//--- hw/bpred/ifu_bp_ctl.sv
//****************************************
// ifu branch predictor
// direct mapped btb with 2-bit counters
//****************************************
`timescale 1ns/1ps
`default_nettype none

module ifu_bp_ctl
   import ifu_cfg_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n,
   input  logic          fetch_req_f1,
   input  logic [PC_W:2] fetch_addr_f1,
   input  logic          fetch_val_f2,
   input  logic          exu_bp_upd_valid,
   input  logic [PC_W:1] exu_bp_upd_pc,     // branch end halfword
   input  logic          exu_bp_upd_taken,
   input  logic [PC_W:1] exu_bp_upd_target,
   output logic          bp_taken_f2,
   output logic [PC_W:1] bp_target_f2,
   output logic          bp_boffset_f2
);

   //****************************************
   // btb storage
   //****************************************
   logic [BTB_DEPTH-1:0]                btb_valid;
   logic [BTB_DEPTH-1:0][BTB_TAG_W-1:0] btb_tag;
   logic [BTB_DEPTH-1:0]                btb_boff;     // halfword of branch end
   logic [BTB_DEPTH-1:0][PC_W:1]        btb_target;
   logic [BTB_DEPTH-1:0][CNT_W-1:0]     btb_cnt;

   logic [BTB_INDEX_W-1:0] rd_idx;
   logic [BTB_TAG_W-1:0]   rd_tag;
   logic                   rd_taken;      // hit with counter msb set
   logic [BTB_INDEX_W-1:0] wr_idx;
   logic [BTB_TAG_W-1:0]   wr_tag;
   logic                   wr_hit;
   logic                   wr_en;
   logic [CNT_W-1:0]       cnt_cur;
   logic [CNT_W-1:0]       cnt_next;
   logic                   hit_q;         // registered f1 lookup

   // f1 lookup
   assign rd_idx   = fetch_addr_f1[BTB_INDEX_LO +: BTB_INDEX_W];
   assign rd_tag   = fetch_addr_f1[BTB_TAG_LO +: BTB_TAG_W];
   assign rd_taken = btb_valid[rd_idx] & (btb_tag[rd_idx] == rd_tag)
                     & btb_cnt[rd_idx][CNT_W-1];

   // update side
   assign wr_idx  = exu_bp_upd_pc[BTB_INDEX_LO +: BTB_INDEX_W];
   assign wr_tag  = exu_bp_upd_pc[BTB_TAG_LO +: BTB_TAG_W];
   assign wr_hit  = btb_valid[wr_idx] & (btb_tag[wr_idx] == wr_tag)
                    & (btb_boff[wr_idx] == exu_bp_upd_pc[1]);
   assign wr_en   = exu_bp_upd_valid & (wr_hit | exu_bp_upd_taken);  // not-taken never allocs
   assign cnt_cur = btb_cnt[wr_idx];

   always_comb begin
      cnt_next = cnt_cur;
      if (!wr_hit) begin
         cnt_next = CNT_WEAK_TAKEN;                        // fresh entry
      end else if (exu_bp_upd_taken && (cnt_cur != {CNT_W{1'b1}})) begin
         cnt_next = cnt_cur + 1'b1;                        // saturate up
      end else if (!exu_bp_upd_taken && (cnt_cur != '0)) begin
         cnt_next = cnt_cur - 1'b1;                        // saturate down
      end
   end

   //****************************************
   // array write and f2 register
   //****************************************
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         btb_valid  <= '0;
         btb_tag    <= '0;
         btb_boff   <= '0;
         btb_target <= '0;
         btb_cnt    <= '0;
         hit_q      <= 1'b0;
      end else begin
         hit_q <= fetch_req_f1 & rd_taken;
         if (wr_en) begin
            btb_valid[wr_idx] <= 1'b1;
            btb_tag[wr_idx]   <= wr_tag;
            btb_boff[wr_idx]  <= exu_bp_upd_pc[1];
            btb_cnt[wr_idx]   <= cnt_next;
            if (exu_bp_upd_taken) begin
               btb_target[wr_idx] <= exu_bp_upd_target;   // latest resolved target
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      bp_target_f2  <= btb_target[rd_idx];
      bp_boffset_f2 <= btb_boff[rd_idx];
   end

   assign bp_taken_f2 = hit_q & fetch_val_f2;   // only a live word predicts

endmodule : ifu_bp_ctl

`default_nettype wire

//--- hw/fetch/ifu_fetch_ctl.sv
//****************************************
// ifu fetch control
// pc register, next fetch select, f2 tracking
//****************************************
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch_ctl
   import ifu_cfg_pkg::*;
(
   input  logic          clk,
   input  logic          arst_n,
   input  logic          exu_flush_final,       // highest priority redirect
   input  logic [PC_W:1] exu_flush_path_final,
   input  logic          bp_taken_f2,           // predicted redirect
   input  logic [PC_W:1] bp_target_f2,
   output logic          fetch_req_f1,
   output logic [PC_W:2] fetch_addr_f1,
   output logic          fetch_val_f2,
   output logic [PC_W:1] fetch_pc_f2,
   output logic          fetch_restart_f2
);

   logic [PC_W:1] pc;           // halfword pc of the f1 fetch
   logic [PC_W:1] pc_next;
   logic          fetch_on;     // set once out of reset
   logic          redirect;     // flush or taken prediction
   logic          restart_f1;   // f1 fetch is first after redirect
   logic          val_f2_q;     // f1 fetch survived into f2
   logic          restart_f2_q;

   assign redirect = exu_flush_final | bp_taken_f2;

   //****************************************
   // next fetch select
   //****************************************
   always_comb begin
      if (exu_flush_final) begin
         pc_next = exu_flush_path_final;               // flush wins
      end else if (bp_taken_f2) begin
         pc_next = bp_target_f2;                       // predicted target
      end else if (fetch_on) begin
         pc_next = {pc[PC_W:2] + 1'b1, 1'b0};          // next word, aligned
      end else begin
         pc_next = pc;                                 // hold at reset vector
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fetch_on     <= 1'b0;
         pc           <= RESET_VECTOR[PC_W:1];
         restart_f1   <= 1'b1;                         // first word starts clean
         val_f2_q     <= 1'b0;
         restart_f2_q <= 1'b0;
      end else begin
         fetch_on     <= 1'b1;
         pc           <= pc_next;
         restart_f1   <= redirect | (restart_f1 & ~fetch_on);
         val_f2_q     <= fetch_on & ~redirect;         // kill fetch issued this cycle
         restart_f2_q <= restart_f1;
      end
   end

   always_ff @(posedge clk) begin
      fetch_pc_f2 <= pc;                               // bit 1 marks odd start
   end

   assign fetch_req_f1     = fetch_on;
   assign fetch_addr_f1    = pc[PC_W:2];
   assign fetch_val_f2     = val_f2_q & ~exu_flush_final;  // flush drops f2 word too
   assign fetch_restart_f2 = restart_f2_q;

endmodule : ifu_fetch_ctl

`default_nettype wire

//--- hw/ifu_top.sv
//****************************************
// ifu top level
// fetch control, branch predictor and aligner
//****************************************
`timescale 1ns/1ps
`default_nettype none

module ifu_top
   import ifu_cfg_pkg::*;
   import ifu_inst_pkg::*;
(
   input  logic                          clk,
   input  logic                          arst_n,

   input  logic                          exu_flush_final,       // redirect strobe
   input  logic [PC_W:1]                 exu_flush_path_final,  // redirect halfword address

   input  logic                          exu_bp_upd_valid,      // branch resolved
   input  logic [PC_W:1]                 exu_bp_upd_pc,         // last halfword of branch
   input  logic                          exu_bp_upd_taken,
   input  logic [PC_W:1]                 exu_bp_upd_target,

   output logic                          ic_rd_en,              // memory read strobe
   output logic [PC_W:2]                 ic_rw_addr,            // word address
   input  logic [2*PARCEL_W-1:0]         ic_rd_data,            // data one cycle later

   output logic                          ifu_i0_valid,          // older instruction
   output logic [$bits(inst_word_u)-1:0] ifu_i0_instr,
   output logic [PC_W:1]                 ifu_i0_pc,
   output logic                          ifu_i0_pc4,
   output logic                          ifu_i0_br_taken,
   output logic [PC_W:1]                 ifu_i0_br_target,

   output logic                          ifu_i1_valid,          // younger, only with i0
   output logic [$bits(inst_word_u)-1:0] ifu_i1_instr,
   output logic [PC_W:1]                 ifu_i1_pc,
   output logic                          ifu_i1_pc4,
   output logic                          ifu_i1_br_taken,
   output logic [PC_W:1]                 ifu_i1_br_target
);

   logic          fetch_req_f1;      // f1 request
   logic [PC_W:2] fetch_addr_f1;     // f1 word address
   logic          fetch_val_f2;      // f2 word live
   logic [PC_W:1] fetch_pc_f2;       // first valid halfword in f2
   logic          fetch_restart_f2;  // first word after a redirect
   logic          bp_taken_f2;       // predicted taken, qualified
   logic [PC_W:1] bp_target_f2;
   logic          bp_boffset_f2;     // halfword where the branch ends

   // memory sees the f1 request directly
   assign ic_rd_en   = fetch_req_f1;
   assign ic_rw_addr = fetch_addr_f1;

   //****************************************
   // pipeline blocks
   //****************************************
   ifu_fetch_ctl ifc (.*);   // pc and next fetch

   ifu_bp_ctl bp (.*);       // btb lookup in parallel with fetch

   ifu_aln_ctl aln (.*);     // parcels to instructions

endmodule : ifu_top

`default_nettype wire

//--- testbench/ifu_sva.sv
//****************************************
// ifu assertions, bound to the top level
//****************************************
`timescale 1ns/1ps
`default_nettype none

module ifu_sva (
   input logic        clk,
   input logic        arst_n,
   input logic        exu_flush_final,
   input logic [31:1] exu_flush_path_final,
   input logic        ic_rd_en,
   input logic [31:2] ic_rw_addr,
   input logic        ifu_i0_valid,
   input logic [31:1] ifu_i0_pc,
   input logic        ifu_i0_pc4,
   input logic        ifu_i1_valid,
   input logic [31:1] ifu_i1_pc
);

   int sva_errors = 0;   // failure count

   a_i1_needs_i0 : assert property (@(posedge clk) disable iff (!arst_n)
      ifu_i1_valid |-> ifu_i0_valid)
      else begin
         $error("i1 valid without i0");
         sva_errors++;
      end

   a_rd_en_on : assert property (@(posedge clk) disable iff (!arst_n)
      $past(arst_n) |-> ic_rd_en)
      else begin
         $error("ic_rd_en low after reset");
         sva_errors++;
      end

   a_flush_word : assert property (@(posedge clk) disable iff (!arst_n)
      exu_flush_final |=> (ic_rd_en && ic_rw_addr == $past(exu_flush_path_final[31:2])))
      else begin
         $error("fetch after flush not at flush word");
         sva_errors++;
      end

   a_i1_pc : assert property (@(posedge clk) disable iff (!arst_n)
      ifu_i1_valid |-> (ifu_i1_pc == ifu_i0_pc + (ifu_i0_pc4 ? 31'd2 : 31'd1)))
      else begin
         $error("i1 pc does not follow i0");
         sva_errors++;
      end

endmodule : ifu_sva

bind ifu_top ifu_sva sva (.*);

`default_nettype wire

//--- testbench/tb_clk_gen.sv
//****************************************
// testbench clock and reset
// 4 ns clock, reset low for 5 cycles
//****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk    = 1'b0;
      arst_n = 1'b0;                  // held from time zero
      forever #2 clk = ~clk;          // 4 ns period
   end

   initial begin
      repeat (5) @(posedge clk);
      arst_n <= 1'b1;                 // release on an edge
   end

endmodule : tb_clk_gen

`default_nettype wire

//--- testbench/tb_ifu.sv
//****************************************
// ifu testbench
// memory model, programs, reference walk and compare
//****************************************
`timescale 1ns/1ps
`default_nettype none

module tb_ifu
   import ifu_cfg_pkg::*;
   import ifu_inst_pkg::*;
();

   localparam int TOTAL_LEN = 310;                    // instructions over all tests

   logic        clk;
   logic        arst_n;
   logic        exu_flush_final;
   logic [31:1] exu_flush_path_final;
   logic        exu_bp_upd_valid;
   logic        exu_bp_upd_taken;
   logic [31:1] exu_bp_upd_pc;
   logic [31:1] exu_bp_upd_target;
   logic        ic_rd_en;
   logic [31:2] ic_rw_addr;
   logic [31:0] ic_rd_data;
   logic        ifu_i0_valid, ifu_i1_valid;
   logic [31:0] ifu_i0_instr, ifu_i1_instr;
   logic [31:1] ifu_i0_pc, ifu_i1_pc;
   logic        ifu_i0_pc4, ifu_i1_pc4;
   logic        ifu_i0_br_taken, ifu_i1_br_taken;
   logic [31:1] ifu_i0_br_target, ifu_i1_br_target;
   logic [15:0] hmem [0:2047];                        // program as halfwords
   logic [30:0] q_pc[$], q_tgt[$], m_tgt[0:2047];
   logic [31:0] q_instr[$];
   bit q_pc4[$], q_tk[$], m_val[0:2047];
   logic [1:0] m_cnt[0:2047];                         // mirrored btb counters
   int seed = 32'h6954;
   int errors = 0, failed = 0, tests = 0;
   logic armed = 1'b1;
   string cur_test = "reset";

   tb_clk_gen clkgen (.clk(clk), .arst_n(arst_n));
   ifu_top dut (.*);

   // data one cycle after request
   always @(posedge clk) begin
      if (ic_rd_en) begin
         ic_rd_data <= {hmem[{ic_rw_addr[11:2], 1'b1}], hmem[{ic_rw_addr[11:2], 1'b0}]};
      end
   end

   task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act) begin
         errors++;
         $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
      end
   endtask

   // expected stream from a halfword pc, following the mirrored btb
   function automatic void ref_walk(input int start, input int n);
      int h;
      int e;
      bit full;
      h       = start;
      q_pc    = {};
      q_instr = {};
      q_pc4   = {};
      q_tk    = {};
      q_tgt   = {};
      repeat (n) begin
         full = (hmem[h][1:0] == OPC_FULL);
         e = full ? h + 1 : h;                        // last halfword of the instr
         q_pc.push_back(h);
         q_instr.push_back(full ? {hmem[h+1], hmem[h]} : {16'h0, hmem[h]});
         q_pc4.push_back(full);
         q_tk.push_back(m_val[e] && m_cnt[e][1]);
         q_tgt.push_back(q_tk[$] ? m_tgt[e] : 31'h0);
         h = q_tk[$] ? int'(m_tgt[e]) : e + 1;
      end
   endfunction

   task automatic compare_slot(input logic [30:0] pc, input logic [31:0] instr, input bit pc4,
                               input bit tk, input logic [30:0] tgt);
      if (q_pc.size() == 0) return;                   // stream already complete
      check("pc", q_pc.pop_front(), pc);
      check("instr", q_instr.pop_front(), instr);
      check("pc4", q_pc4.pop_front(), pc4);
      check("br_taken", q_tk.pop_front(), tk);
      check("br_target", q_tgt.pop_front(), tgt);
   endtask

   always @(negedge clk) begin                        // i0 is older, then i1
      if (armed && ifu_i0_valid) compare_slot(ifu_i0_pc, ifu_i0_instr, ifu_i0_pc4,
                                              ifu_i0_br_taken, ifu_i0_br_target);
      if (armed && ifu_i1_valid) compare_slot(ifu_i1_pc, ifu_i1_instr, ifu_i1_pc4,
                                              ifu_i1_br_taken, ifu_i1_br_target);
   end

   task automatic bp_update(input int pc, input bit taken, input int tgt);
      @(posedge clk);
      exu_bp_upd_valid  <= 1'b1;
      exu_bp_upd_pc     <= pc;
      exu_bp_upd_taken  <= taken;
      exu_bp_upd_target <= tgt;
      @(posedge clk);
      exu_bp_upd_valid  <= 1'b0;
      if (taken) begin                                // saturating counter rule
         m_cnt[pc] = !m_val[pc] ? 2'b10 : (m_cnt[pc] == 2'b11 ? 2'b11 : m_cnt[pc] + 2'd1);
         m_val[pc] = 1'b1;
         m_tgt[pc] = tgt;
      end else if (m_val[pc] && m_cnt[pc] != 2'b00) begin
         m_cnt[pc] = m_cnt[pc] - 2'd1;
      end
   endtask

   task automatic finish_test(input int e0);
      while (q_pc.size() != 0) @(posedge clk);
      armed <= 1'b0;
      tests++;
      if (errors != e0) failed++;
      $display("test %s: %s", cur_test, (errors == e0) ? "ok" : "failed");
   endtask

   task automatic flush_test(input string name, input int start, input int n);
      int e0;
      e0       = errors;
      cur_test = name;
      ref_walk(start, n);
      @(posedge clk);
      exu_flush_final      <= 1'b1;
      exu_flush_path_final <= start;
      @(posedge clk);
      exu_flush_final <= 1'b0;
      armed           <= 1'b1;
      finish_test(e0);
   endtask

   initial begin
      #((TOTAL_LEN * 4 + 100) * 4);                   // four cycles per instruction
      $display("timeout: the instruction stream stopped before all tests finished");
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      int h, e0, br;
      logic [31:0] r;
      {exu_flush_final, exu_bp_upd_valid, exu_bp_upd_taken} = '0;
      {exu_flush_path_final, exu_bp_upd_pc, exu_bp_upd_target, ic_rd_data} = '0;
      for (h = 0; h < 2048; h++) m_val[h] = 1'b0;
      h = 0;
      while (h < 2048) begin                          // random 16/32-bit parcel mix
         r = $random(seed);
         if (r[0] && h < 2047) begin
            hmem[h]   = {r[31:18], 2'b11};
            hmem[h+1] = $random(seed);
            h += 2;
         end else begin
            hmem[h] = {r[15:1], 1'b0};
            h++;
         end
      end
      e0 = errors;
      ref_walk(RESET_VECTOR[31:1], 20);
      @(negedge clk) check("valid in reset", 0, ifu_i0_valid | ifu_i1_valid);
      do @(negedge clk); while (!ic_rd_en);
      check("first fetch", RESET_VECTOR[31:2], ic_rw_addr);
      finish_test(e0);
      flush_test("random_mix", 'h180, 200);
      flush_test("flush_odd", 'h401, 30);
      ref_walk('h500, 6);                             // branch ends the 6th instr
      br = q_pc[5] + q_pc4[5];
      bp_update(br, 1'b1, 'h600);
      flush_test("branch_taken", 'h500, 20);
      bp_update(br, 1'b1, 'h600);
      bp_update(br, 1'b1, 'h600);
      bp_update(br, 1'b0, 'h600);
      flush_test("bp_one_not_taken", 'h500, 20);
      bp_update(br, 1'b0, 'h600);
      flush_test("bp_two_not_taken", 'h500, 20);
      errors += dut.sva.sva_errors;
      $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
      if (errors == 0) $display("=== PASS ===");
      else $display("=== FAIL ===");
      $finish;
   end

endmodule : tb_ifu

`default_nettype wire
